//--- hw/rtc_pkg.sv
// Clock byte, time, control and FSM state types; register indices and limits.
package rtc_pkg;

    typedef logic [7:0] byte_t;

    typedef struct packed {
        byte_t second;
        byte_t minute;
        byte_t hour;
    } rtc_time_t;

    typedef struct packed {
        logic binary_mode;      // 1 = binary, 0 = BCD.
        logic halt;             // Freeze or divider 11x.
        logic int_alarm_ena;
        logic int_update_ena;
    } rtc_ctrl_t;

    typedef struct packed {
        logic  strobe;
        byte_t data;
    } field_wr_t;

    typedef enum logic [2:0] {
        update_start,
        update_in_progress,
        second_start,
        second_in_progress,
        stopped
    } sec_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register indices on the data port.
    localparam logic [6:0] REG_SECOND       = 7'h00;
    localparam logic [6:0] REG_ALARM_SECOND = 7'h01;
    localparam logic [6:0] REG_MINUTE       = 7'h02;
    localparam logic [6:0] REG_ALARM_MINUTE = 7'h03;
    localparam logic [6:0] REG_HOUR         = 7'h04;
    localparam logic [6:0] REG_ALARM_HOUR   = 7'h05;
    localparam logic [6:0] REG_A            = 7'h0A;
    localparam logic [6:0] REG_B            = 7'h0B;
    localparam logic [6:0] REG_C            = 7'h0C;
    localparam logic [6:0] REG_D            = 7'h0D;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [27:0] TICK_HZ          = 28'd800;
    localparam logic [10:0] SEC_TICKS_RELOAD = 11'd799;   // Ticks per second, less one.
    localparam logic [10:0] START_TICKS      = 11'd4;     // Short first second.

    // Binary maxima, 24-hour mode.
    localparam byte_t SECOND_MAX = 8'd59;
    localparam byte_t MINUTE_MAX = 8'd59;
    localparam byte_t HOUR_MAX   = 8'd23;

endpackage

//--- hw/rtc_tick_gen.sv
// Fractional accumulator dividing the system clock down to the 800 Hz tick.
`timescale 1ns/1ns

module rtc_tick_gen
    import rtc_pkg::*;
#(
    parameter logic [27:0] clk_rate = 28'd50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    logic [27:0] acc;
    logic [27:0] sum;

    assign sum = acc + TICK_HZ;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= clk_rate) begin
            acc  <= sum - clk_rate;     // Remainder carries over.
            tick <= 1'b1;
        end else begin
            acc  <= sum;
            tick <= 1'b0;
        end
    end

    // Fast clock, so ticks stay isolated.
    assert property (@(posedge clk) disable iff (!rst_n)
        (clk_rate > 2 * TICK_HZ) && tick |=> !tick);

endmodule

//--- hw/rtc_second_fsm.sv
// Once-per-second update state machine with its tick timeout counter.
`timescale 1ns/1ns

module rtc_second_fsm
    import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tick,
    input  rtc_ctrl_t ctrl,
    output logic      second_step,
    output logic      uip
);

    sec_state_e  state;
    logic [10:0] timeout;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= update_start;
        end else if (ctrl.halt) begin
            state <= stopped;
        end else begin
            case (state)
                stopped:            state <= update_start;   // Restart after halt.
                update_start:       state <= update_in_progress;
                update_in_progress: begin
                    if (timeout == '0) begin
                        state <= second_start;
                    end
                end
                second_start:       state <= second_in_progress;
                second_in_progress: begin
                    if (timeout == 11'd1) begin
                        state <= update_start;
                    end
                end
                default:            state <= update_start;
            endcase
        end
    end

    // Counts ticks; reloads itself at zero.
    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.halt) begin
            timeout <= START_TICKS;
        end else if (timeout == '0) begin
            timeout <= SEC_TICKS_RELOAD;
        end else if (tick) begin
            timeout <= timeout - 11'd1;
        end
    end

    assign second_step = (state == second_start);
    assign uip         = (state == update_in_progress) || (state == second_start);

    assert property (@(posedge clk) disable iff (!rst_n)
        second_step |=> !second_step);

endmodule

//--- hw/rtc_time_field.sv
// One rolling time byte with BCD or binary stepping and a carry out.
`timescale 1ns/1ns

module rtc_time_field
    import rtc_pkg::*;
#(
    parameter byte_t field_max = SECOND_MAX
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    input  rtc_ctrl_t ctrl,
    input  field_wr_t wr,
    output byte_t     value,
    output byte_t     next_value,
    output logic      carry
);

    // Same limit as two packed BCD digits.
    localparam byte_t bcd_max = {4'(field_max / 10), 4'(field_max % 10)};

    logic at_max;

    // A plain byte compare also orders packed BCD correctly.
    assign at_max = ctrl.binary_mode ? (value >= field_max) : (value >= bcd_max);

    always_comb begin
        if (at_max) begin
            next_value = '0;
        end else if (!ctrl.binary_mode && value[3:0] >= 4'd9) begin
            next_value = {value[7:4] + 4'd1, 4'h0};    // Low digit wraps into tens.
        end else begin
            next_value = value + 8'd1;
        end
    end

    assign carry = step && at_max;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
        end else if (wr.strobe) begin
            value <= wr.data;      // Host write beats the step.
        end else if (step) begin
            value <= next_value;
        end
    end

endmodule

//--- hw/rtc_regs.sv
// Index and data ports, registers A to D, alarm bytes, interrupt flags and irq.
`timescale 1ns/1ns

module rtc_regs
    import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      io_address,
    input  logic      io_read,
    input  logic      io_write,
    input  byte_t     io_writedata,
    output byte_t     io_readdata,
    output logic      irq,
    input  rtc_time_t time_now,
    input  rtc_time_t time_next,
    input  logic      minute_carry,     // Minute field steps now.
    input  logic      hour_carry,       // Hour field steps now.
    input  logic      second_step,
    input  logic      uip,
    output rtc_ctrl_t ctrl,
    output field_wr_t sec_wr,
    output field_wr_t min_wr,
    output field_wr_t hour_wr
);

    logic [6:0] index;
    logic [2:0] divider;
    logic       freeze;
    logic       alarm_ena;
    logic       update_ena;
    logic       binary_mode;
    byte_t      alarm_second;
    byte_t      alarm_minute;
    byte_t      alarm_hour;
    logic       read_last;
    logic       data_wr;
    logic       read_c;
    logic       update_flag;
    logic       alarm_flag;
    logic       alarm_hit;
    byte_t      minute_after;
    byte_t      hour_after;
    byte_t      read_next;

    assign data_wr = io_write && io_address;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host writes.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index       <= '0;
            divider     <= 3'b010;
            freeze      <= 1'b0;
            alarm_ena   <= 1'b0;
            update_ena  <= 1'b0;
            binary_mode <= 1'b0;
        end else if (io_write && !io_address) begin
            index <= io_writedata[6:0];
        end else if (data_wr && index == REG_A) begin
            divider <= io_writedata[6:4];
        end else if (data_wr && index == REG_B) begin
            freeze      <= io_writedata[7];
            alarm_ena   <= io_writedata[5];
            update_ena  <= io_writedata[4] && !io_writedata[7];    // Off under freeze.
            binary_mode <= io_writedata[2];
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr && index == REG_ALARM_SECOND) alarm_second <= io_writedata;
        if (data_wr && index == REG_ALARM_MINUTE) alarm_minute <= io_writedata;
        if (data_wr && index == REG_ALARM_HOUR)   alarm_hour   <= io_writedata;
    end

    assign sec_wr  = '{strobe: data_wr && index == REG_SECOND, data: io_writedata};
    assign min_wr  = '{strobe: data_wr && index == REG_MINUTE, data: io_writedata};
    assign hour_wr = '{strobe: data_wr && index == REG_HOUR,   data: io_writedata};

    assign ctrl.binary_mode    = binary_mode;
    assign ctrl.halt           = freeze || divider[2:1] == 2'b11;
    assign ctrl.int_alarm_ena  = alarm_ena;
    assign ctrl.int_update_ena = update_ena;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flags and irq.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_last <= 1'b0;
        end else begin
            read_last <= io_read;
        end
    end

    // Only the first cycle of a read of C clears.
    assign read_c = io_read && !read_last && io_address && index == REG_C;

    // Time as it stands after this step.
    assign minute_after = minute_carry ? time_next.minute : time_now.minute;
    assign hour_after   = hour_carry ? time_next.hour : time_now.hour;

    assign alarm_hit = (alarm_second[7:6] == 2'b11 || alarm_second == time_next.second)
                    && (alarm_minute[7:6] == 2'b11 || alarm_minute == minute_after)
                    && (alarm_hour[7:6] == 2'b11 || alarm_hour == hour_after);

    always_ff @(posedge clk) begin
        if (!rst_n || read_c) begin
            update_flag <= 1'b0;
            alarm_flag  <= 1'b0;
            irq         <= 1'b0;
        end else begin
            if (second_step) update_flag <= 1'b1;
            if (second_step && alarm_hit) alarm_flag <= 1'b1;
            if (!irq && ((alarm_ena && alarm_flag) || (update_ena && update_flag))) begin
                irq <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !irq && !alarm_ena && !update_ena |=> !irq);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux, registered.

    always_comb begin
        read_next = 8'h00;
        if (!io_address) begin
            read_next = 8'hFF;     // Index port is write only.
        end else begin
            case (index)
                REG_SECOND:       read_next = time_now.second;
                REG_ALARM_SECOND: read_next = alarm_second;
                REG_MINUTE:       read_next = time_now.minute;
                REG_ALARM_MINUTE: read_next = alarm_minute;
                REG_HOUR:         read_next = time_now.hour;
                REG_ALARM_HOUR:   read_next = alarm_hour;
                REG_A:            read_next = {uip, divider, 4'h0};
                // Bit 1 reports the fixed 24-hour mode.
                REG_B:   read_next = {freeze, 1'b0, alarm_ena, update_ena,
                                      1'b0, binary_mode, 1'b1, 1'b0};
                REG_C:   read_next = {irq, 1'b0, alarm_flag, update_flag, 4'h0};
                REG_D:   read_next = 8'h80;      // Battery good.
                default: read_next = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        io_readdata <= read_next;
    end

endmodule

//--- hw/rtc_top.sv
// Real-time clock top level joining tick, update FSM, time fields and registers.
`timescale 1ns/1ns

module rtc_top
    import rtc_pkg::*;
#(
    parameter logic [27:0] clk_rate = 28'd50_000_000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  io_address,
    input  logic  io_read,
    input  logic  io_write,
    input  byte_t io_writedata,
    output byte_t io_readdata,
    output logic  irq
);

    logic           tick;
    logic           second_step;
    logic           uip;
    logic           sec_carry;     // Steps the minute.
    logic           min_carry;     // Steps the hour.
    rtc_ctrl_t      ctrl;
    field_wr_t      sec_wr;
    field_wr_t      min_wr;
    field_wr_t      hour_wr;
    wire rtc_time_t time_now;
    wire rtc_time_t time_next;

    rtc_tick_gen #(.clk_rate(clk_rate)) tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    rtc_second_fsm second_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .ctrl        (ctrl),
        .second_step (second_step),
        .uip         (uip)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field chain, each carry steps the next.

    rtc_time_field #(.field_max(SECOND_MAX)) second_field (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (second_step),
        .ctrl       (ctrl),
        .wr         (sec_wr),
        .value      (time_now.second),
        .next_value (time_next.second),
        .carry      (sec_carry)
    );

    rtc_time_field #(.field_max(MINUTE_MAX)) minute_field (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (sec_carry),
        .ctrl       (ctrl),
        .wr         (min_wr),
        .value      (time_now.minute),
        .next_value (time_next.minute),
        .carry      (min_carry)
    );

    // Day counter is absent, so the hour wrap goes nowhere.
    rtc_time_field #(.field_max(HOUR_MAX)) hour_field (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (min_carry),
        .ctrl       (ctrl),
        .wr         (hour_wr),
        .value      (time_now.hour),
        .next_value (time_next.hour),
        .carry      ()
    );

    rtc_regs regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .irq          (irq),
        .time_now     (time_now),
        .time_next    (time_next),
        .minute_carry (sec_carry),
        .hour_carry   (min_carry),
        .second_step  (second_step),
        .uip          (uip),
        .ctrl         (ctrl),
        .sec_wr       (sec_wr),
        .min_wr       (min_wr),
        .hour_wr      (hour_wr)
    );

endmodule

//--- verification/rtc_tb.sv
// Testbench for the real-time clock with bus tasks, compare tasks, stimulus table and watchdog.
`timescale 1ns/1ns

module rtc_tb
    import rtc_pkg::*;
();

    localparam int num_rows        = 6;
    localparam int sec_cycles      = 1600;                 // 800 ticks, one every two cycles.
    localparam int two_sec_cycles  = 2 * sec_cycles + 200;
    localparam int irq_limit       = 2 * sec_cycles + 200;
    localparam int watchdog_cycles = (num_rows + 4) * 2000;

    typedef struct packed {
        logic      binary;
        rtc_time_t start;
        rtc_time_t alarm;
        logic      alarm_ena;
        logic      update_ena;
        rtc_time_t expect_time;
        byte_t     expect_c;        // Bit 7 clear means irq must stay low.
    } row_t;

    logic  clk;
    logic  rst_n;
    logic  io_address;
    logic  io_read;
    logic  io_write;
    byte_t io_writedata;
    byte_t io_readdata;
    logic  irq;

    row_t  rows [num_rows];
    byte_t setup_vals [6];
    int    errors;
    int    tests;
    int    failed_tests;

    rtc_top #(.clk_rate(28'd1600)) rtc_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .irq          (irq)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers and compare tasks.

    function automatic rtc_time_t make_time(byte_t hour, byte_t minute, byte_t second);
        rtc_time_t t;
        t.hour   = hour;
        t.minute = minute;
        t.second = second;
        return t;
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t expected);
        if (got !== expected) begin
            $display("ERR t=%0t %s got %02h expected %02h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_time(input string name, input rtc_time_t got, input rtc_time_t expected);
        if (got !== expected) begin
            $display("ERR t=%0t %s got %02h:%02h:%02h expected %02h:%02h:%02h", $time, name,
                     got.hour, got.minute, got.second,
                     expected.hour, expected.minute, expected.second);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus tasks. Inputs move 2 ns after the rising edge.

    task automatic io_wr(input logic [6:0] index, input byte_t data);
        @(posedge clk); #2;
        io_address   = 1'b0;                // Index port.
        io_write     = 1'b1;
        io_writedata = {1'b0, index};
        @(posedge clk); #2;
        io_address   = 1'b1;
        io_writedata = data;
        @(posedge clk); #2;
        io_write     = 1'b0;
    endtask

    task automatic io_rd(input logic [6:0] index, output byte_t data);
        @(posedge clk); #2;
        io_address   = 1'b0;
        io_write     = 1'b1;
        io_writedata = {1'b0, index};
        @(posedge clk); #2;
        io_write     = 1'b0;
        io_address   = 1'b1;
        io_read      = 1'b1;
        @(posedge clk); #2;
        data         = io_readdata;         // Registered one cycle after the read.
        io_read      = 1'b0;
    endtask

    task automatic write_time(input rtc_time_t t);
        io_wr(REG_SECOND, t.second);
        io_wr(REG_MINUTE, t.minute);
        io_wr(REG_HOUR, t.hour);
    endtask

    task automatic read_time(output rtc_time_t t);
        io_rd(REG_SECOND, t.second);
        io_rd(REG_MINUTE, t.minute);
        io_rd(REG_HOUR, t.hour);
    endtask

    task automatic wait_irq(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < irq_limit) begin
            @(posedge clk); #2;
            seen = irq;
            n++;
        end
    endtask

    task automatic watch_quiet(input int cycles, output logic rose);
        rose = 1'b0;
        repeat (cycles) begin
            @(posedge clk); #2;
            if (irq) rose = 1'b1;
        end
    endtask

    // Polls register A over two seconds, then checks that the time held.
    task automatic watch_stopped(input rtc_time_t expected);
        byte_t     data;
        rtc_time_t now;
        repeat (two_sec_cycles / 200) begin
            repeat (200) @(posedge clk);
            io_rd(REG_A, data);
            check_byte("reg_a bit 7", data & 8'h80, 8'h00);
        end
        read_time(now);
        check_time("stopped time", now, expected);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog.

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int        e0;
        byte_t     data;
        rtc_time_t now;
        logic      seen;
        row_t      r;

        clk          = 1'b0;
        rst_n        = 1'b0;
        io_address   = 1'b0;
        io_read      = 1'b0;
        io_write     = 1'b0;
        io_writedata = 8'h00;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;

        // Values for indices 0 to 5 in order.
        setup_vals = '{8'h45, 8'h12, 8'h33, 8'h34, 8'h21, 8'hC0};

        // Mode, start, alarm, alarm ena, update ena, time after one second, register C.
        rows[0] = '{1'b0, make_time(8'h23, 8'h59, 8'h59), make_time(8'h12, 8'h20, 8'h10),
                    1'b0, 1'b1, make_time(8'h00, 8'h00, 8'h00), 8'h90};
        rows[1] = '{1'b0, make_time(8'h09, 8'h09, 8'h09), make_time(8'h01, 8'h02, 8'h03),
                    1'b0, 1'b1, make_time(8'h09, 8'h09, 8'h10), 8'h90};
        rows[2] = '{1'b1, make_time(8'h0C, 8'h3B, 8'h3B), make_time(8'h01, 8'h02, 8'h03),
                    1'b0, 1'b1, make_time(8'h0D, 8'h00, 8'h00), 8'h90};
        rows[3] = '{1'b0, make_time(8'h10, 8'h30, 8'h15), make_time(8'h10, 8'h30, 8'h16),
                    1'b1, 1'b1, make_time(8'h10, 8'h30, 8'h16), 8'hB0};
        rows[4] = '{1'b1, make_time(8'h05, 8'h06, 8'h07), make_time(8'hC0, 8'h06, 8'h08),
                    1'b1, 1'b0, make_time(8'h05, 8'h06, 8'h08), 8'hB0};
        rows[5] = '{1'b0, make_time(8'h14, 8'h20, 8'h00), make_time(8'h14, 8'h45, 8'h01),
                    1'b1, 1'b0, make_time(8'h14, 8'h20, 8'h01), 8'h10};

        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;

        // Set and read back under freeze.
        e0 = errors;
        io_wr(REG_B, 8'h82);
        for (int i = 0; i < 6; i++) io_wr(7'(i), setup_vals[i]);
        for (int i = 0; i < 6; i++) begin
            io_rd(7'(i), data);
            check_byte($sformatf("reg_%02h", i), data, setup_vals[i]);
        end
        io_rd(REG_D, data);
        check_byte("reg_d", data, 8'h80);
        io_rd(7'h20, data);
        check_byte("reg_20", data, 8'h00);
        end_test("set and read back", e0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Table rows.
        for (int i = 0; i < num_rows; i++) begin
            r  = rows[i];
            e0 = errors;
            io_wr(REG_B, {5'b10000, r.binary, 2'b10});      // Frozen while loading.
            write_time(r.start);
            io_wr(REG_ALARM_SECOND, r.alarm.second);
            io_wr(REG_ALARM_MINUTE, r.alarm.minute);
            io_wr(REG_ALARM_HOUR, r.alarm.hour);
            io_rd(REG_C, data);                             // Drops stale flags.
            io_wr(REG_B, {2'b00, r.alarm_ena, r.update_ena, 1'b0, r.binary, 2'b10});
            if (r.expect_c[7]) begin
                wait_irq(seen);
                if (!seen) begin
                    $display("row %0d: irq never rose after the first second", i);
                    errors++;
                end
                read_time(now);
                check_time("time", now, r.expect_time);
                io_rd(REG_C, data);
                check_byte("reg_c", data, r.expect_c);
                io_rd(REG_C, data);
                check_byte("reg_c again", data, 8'h00);
                check_byte("irq", {7'b0, irq}, 8'h00);
            end else begin
                watch_quiet(two_sec_cycles, seen);
                if (seen) begin
                    $display("row %0d: irq rose although the alarm cannot match", i);
                    errors++;
                end
                io_rd(REG_C, data);
                check_byte("reg_c", data, r.expect_c);
            end
            end_test($sformatf("row %0d", i), e0);
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Divider 110, then freeze.
        e0 = errors;
        io_wr(REG_B, 8'h82);
        write_time(make_time(8'h11, 8'h22, 8'h33));
        io_wr(REG_A, 8'h60);
        io_wr(REG_B, 8'h12);                                // Freeze off, divider still halts.
        watch_stopped(make_time(8'h11, 8'h22, 8'h33));
        io_wr(REG_B, 8'h82);
        io_wr(REG_A, 8'h20);
        end_test("divider stop", e0);

        e0 = errors;
        write_time(make_time(8'h05, 8'h06, 8'h07));
        watch_stopped(make_time(8'h05, 8'h06, 8'h07));
        end_test("freeze", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/rtc_pkg.sv
hw/rtc_tick_gen.sv
hw/rtc_second_fsm.sv
hw/rtc_time_field.sv
hw/rtc_regs.sv
hw/rtc_top.sv
verification/rtc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the RTC testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rtc_tb \
    -f flist.f -o rtc_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rtc_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$sim_log"; then
    exit 0
fi
exit 1
